//--- tb.f
+incdir+hw
+incdir+dv
hw/fpu_pkg.sv
hw/fpu_req_if.sv
hw/fpu_op_decode.sv
hw/fpu_issue_ctrl.sv
hw/fpu_noncomp_unit.sv
hw/fpu_wrap.sv
dv/tb_fpu_wrap.sv

//--- Bender.yml
package:
  name: fpu_wrap

sources:
  - include_dirs:
      - hw
    files:
      - hw/fpu_pkg.sv
      - hw/fpu_req_if.sv
      - hw/fpu_op_decode.sv
      - hw/fpu_issue_ctrl.sv
      - hw/fpu_noncomp_unit.sv
      - hw/fpu_wrap.sv
  - target: test
    include_dirs:
      - hw
      - dv
    files:
      - dv/tb_fpu_wrap.sv

//--- dv/fpu_tb_model.svh
// reference model for the non-computational fpu operations.

function automatic logic [63:0] nan_box(logic [31:0] x);
    return {32'hffff_ffff, x};
endfunction

function automatic logic is_nan(logic is64, logic [63:0] x);
    if (is64) begin
        return &x[62:52] && |x[51:0];
    end
    return &x[30:23] && |x[22:0];
endfunction

function automatic logic is_snan(logic is64, logic [63:0] x);
    return is_nan(is64, x) && !(is64 ? x[51] : x[22]); // quiet bit clear.
endfunction

// min/max ordering where -0 sorts below +0.
function automatic logic less_than(logic is64, logic [63:0] a, logic [63:0] b);
    logic        sa, sb;
    logic [62:0] ma, mb;
    sa = is64 ? a[63] : a[31];
    sb = is64 ? b[63] : b[31];
    ma = is64 ? a[62:0] : {32'b0, a[30:0]};
    mb = is64 ? b[62:0] : {32'b0, b[30:0]};
    if (sa != sb) begin
        return sa;
    end
    return sa ? (ma > mb) : (ma < mb);
endfunction

function automatic logic [9:0] classify(logic is64, logic [63:0] x);
    logic s, e_ones, e_zero, m_zero;
    s      = is64 ? x[63] : x[31];
    e_ones = is64 ? &x[62:52] : &x[30:23];
    e_zero = is64 ? ~|x[62:52] : ~|x[30:23];
    m_zero = is64 ? ~|x[51:0] : ~|x[22:0];
    if (is_nan(is64, x)) begin
        return is_snan(is64, x) ? 10'h100 : 10'h200;
    end else if (e_ones) begin
        return s ? 10'h001 : 10'h080; // infinity.
    end else if (!e_zero) begin
        return s ? 10'h002 : 10'h040;
    end else if (!m_zero) begin
        return s ? 10'h004 : 10'h020; // subnormal.
    end
    return s ? 10'h008 : 10'h010;
endfunction

function automatic exp_t expect_req(fpu_op_e op, logic [1:0] fmt, logic [2:0] rm,
                                    logic [63:0] a, logic [63:0] b, logic [2:0] tag);
    exp_t        e;
    logic        is64, sa, sb, s, nan_a, nan_b, snan_ab, zeros, eq, lt;
    logic [63:0] pick;
    is64    = (fmt == 2'b01); // every other format code runs as single.
    sa      = is64 ? a[63] : a[31];
    sb      = is64 ? b[63] : b[31];
    nan_a   = is_nan(is64, a);
    nan_b   = is_nan(is64, b);
    snan_ab = is_snan(is64, a) || is_snan(is64, b);
    zeros   = is64 ? (a[62:0] == '0 && b[62:0] == '0) : (a[30:0] == '0 && b[30:0] == '0);
    eq      = !nan_a && !nan_b && (zeros || (is64 ? a == b : a[31:0] == b[31:0]));
    lt      = !nan_a && !nan_b && !zeros && less_than(is64, a, b);
    e.tag    = tag;
    e.res    = '0;
    e.status = '0;
    case (op)
        FSGNJ: begin
            case (rm[1:0])
                2'd0:    s = sb;
                2'd1:    s = !sb;
                2'd2:    s = sa ^ sb;
                default: s = sa;
            endcase
            e.res = is64 ? {s, a[62:0]} : nan_box({s, a[30:0]});
        end
        FMIN_MAX: begin
            if (nan_a && nan_b) begin
                pick = is64 ? `FPU_QNAN64 : {32'b0, `FPU_QNAN32};
            end else if (nan_a) begin
                pick = b;
            end else if (nan_b) begin
                pick = a;
            end else begin
                pick = (less_than(is64, a, b) != rm[0]) ? a : b;
            end
            e.res                     = is64 ? pick : nan_box(pick[31:0]);
            e.status[`FPU_STATUS_W-1] = snan_ab;
        end
        FCMP: begin
            // eq is quiet, le and lt signal on any nan.
            e.res[0]                  = (rm[1:0] == 2'd2) ? eq : (lt || (eq && rm[1:0] == 2'd0));
            e.status[`FPU_STATUS_W-1] = (rm[1:0] == 2'd2) ? snan_ab : (nan_a || nan_b);
        end
        FCLASS:  e.res[9:0] = classify(is64, a);
        FMV_F2X: e.res = is64 ? a : {{32{a[31]}}, a[31:0]};
        FMV_X2F: e.res = is64 ? a : nan_box(a[31:0]);
        default: ;
    endcase
    return e;
endfunction

//--- dv/tb_fpu_wrap.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module tb_fpu_wrap import fpu_pkg::*; ();

    localparam int N_DIRECTED      = 2 * 10 * 16;
    localparam int N_RAND          = 200;
    localparam int NUM_REQS        = N_DIRECTED + N_RAND + 8;
    localparam int WATCHDOG_CYCLES = 40 * NUM_REQS + 200;

    typedef struct packed {
        logic [`FPU_TAG_W-1:0]    tag;
        logic [`FPU_FLEN-1:0]     res;
        logic [`FPU_STATUS_W-1:0] status;
    } exp_t;

    `include "fpu_tb_model.svh"

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    logic                     fpu_valid_i;
    logic                     fpu_ready_o;
    fpu_op_e                  fpu_op_i;
    logic [1:0]               fpu_fmt_i;
    logic [2:0]               fpu_rm_i;
    logic [`FPU_FLEN-1:0]     operand_a_i;
    logic [`FPU_FLEN-1:0]     operand_b_i;
    logic [`FPU_TAG_W-1:0]    trans_id_i;
    logic [`FPU_FLEN-1:0]     result_o;
    logic [`FPU_TAG_W-1:0]    fpu_trans_id_o;
    logic [`FPU_STATUS_W-1:0] fpu_status_o;
    logic                     fpu_valid_o;

    exp_t                  exp_q[$];
    int                    checks = 0;
    int                    errors = 0;
    logic                  saw_stall = 1'b0;
    logic [`FPU_TAG_W-1:0] next_tag = '0;

    // +0, -0, +sub, -sub, +norm, -norm, +inf, -inf, qnan, snan.
    logic [63:0] sp64 [10] = '{
        64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001,
        64'h8008_0000_0000_0000, 64'h3ff0_0000_0000_0000, 64'hc000_0000_0000_0000,
        64'h7ff0_0000_0000_0000, 64'hfff0_0000_0000_0000, 64'h7ff8_0000_0000_0000,
        64'h7ff0_0000_0000_0001
    };
    logic [31:0] sp32 [10] = '{
        32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h8040_0000, 32'h3f80_0000,
        32'hc000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001
    };

    fpu_wrap UUT (.*);

    always #10 clk_i = ~clk_i;

    // index 10 and above gives random bits; single values get random upper halves.
    function automatic logic [63:0] operand(int idx, logic is64);
        logic [63:0] r;
        r = {$urandom, $urandom};
        if (idx < 10) begin
            if (is64) begin
                r = sp64[idx];
            end else begin
                r[31:0] = sp32[idx];
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("ERROR time %0t %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic send(input fpu_op_e op, input logic [1:0] fmt, input logic [2:0] rm,
                        input logic [63:0] a, input logic [63:0] b, input logic flush = 1'b0);
        @(negedge clk_i);
        fpu_valid_i = 1'b1;
        flush_i     = flush;
        fpu_op_i    = op;
        fpu_fmt_i   = fmt;
        fpu_rm_i    = rm;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = next_tag;
        next_tag++;
        @(posedge clk_i);
        while (!fpu_ready_o) begin
            @(posedge clk_i); // held until accepted.
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge clk_i);
        fpu_valid_i = 1'b0;
        flush_i     = 1'b0;
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk_i);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("no result arrived for %0d accepted requests", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // results are checked before new requests are queued.
    always @(posedge clk_i) begin
        exp_t head;
        if (fpu_valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("result with tag %0d at %0t matches no request", fpu_trans_id_o, $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checks++;
                assert (fpu_trans_id_o == head.tag)
                    else report_mismatch("fpu_trans_id_o", 64'(head.tag), 64'(fpu_trans_id_o));
                assert (result_o == head.res)
                    else report_mismatch("result_o", head.res, result_o);
                assert (fpu_status_o == head.status)
                    else report_mismatch("fpu_status_o", 64'(head.status), 64'(fpu_status_o));
            end
        end
        if (flush_i) begin
            exp_q.delete(); // nothing in flight survives a flush.
        end else if (fpu_valid_i && fpu_ready_o) begin
            exp_q.push_back(expect_req(fpu_op_i, fpu_fmt_i, fpu_rm_i, operand_a_i,
                                       operand_b_i, trans_id_i));
        end
        if (fpu_valid_i && !fpu_ready_o) begin
            saw_stall <= 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !fpu_valid_o)
        else begin
            $display("result strobe raised during reset at %0t", $time);
            errors++;
        end

    flush_drops: assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> !fpu_valid_o)
        else begin
            $display("result strobe raised right after a flush at %0t", $time);
            errors++;
        end

    initial begin
        fpu_op_e     op;
        logic [1:0]  fmt;
        logic [63:0] a, b, c;
        void'($urandom(32'h1939_2d09));
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        fpu_op_i    = FSGNJ;
        fpu_fmt_i   = 2'b00;
        fpu_rm_i    = 3'd0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i  = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            assert (fpu_ready_o && !fpu_valid_o) else begin
                $display("handshake not idle after reset at %0t", $time);
                errors++;
            end
        end

        for (int f = 0; f < 2; f++) begin
            fmt = f ? 2'b01 : 2'b00;
            for (int i = 0; i < 10; i++) begin
                a = operand(i, f == 1);
                b = operand((i + 1) % 10, f == 1);
                c = operand(i, f == 1); // same class as a, so nan pairs are both quiet or both signaling.
                send(FCLASS, fmt, 3'd0, a, b);
                send(FMV_F2X, fmt, 3'd0, a, b);
                send(FMV_X2F, fmt, 3'd0, a, b);
                for (int m = 0; m < 3; m++) begin
                    send(FSGNJ, fmt, 3'(m), a, b);
                    send(FCMP, fmt, 3'(m), a, b);
                    send(FCMP, fmt, 3'(m), a, a);
                end
                for (int m = 0; m < 2; m++) begin
                    send(FMIN_MAX, fmt, 3'(m), a, b);
                    send(FMIN_MAX, fmt, 3'(m), a, c);
                end
            end
            drain();
        end

        saw_stall = 1'b0;
        send(FCMP, 2'b01, 3'd1, operand(4, 1), operand(5, 1));
        send(FSGNJ, 2'b01, 3'd2, operand(5, 1), operand(5, 1));
        send(FCLASS, 2'b00, 3'd0, operand(2, 0), operand(0, 0));
        send(FMIN_MAX, 2'b00, 3'd1, operand(4, 0), operand(6, 0));
        drain();
        assert (saw_stall) else begin
            $display("compare followed by sign injection never lowered fpu_ready_o");
            errors++;
        end

        // the class op is in flight when the flush arrives.
        send(FCLASS, 2'b01, 3'd0, operand(6, 1), operand(0, 1));
        send(FSGNJ, 2'b01, 3'd1, operand(4, 1), operand(4, 1), 1'b1);
        send(FSGNJ, 2'b00, 3'd0, operand(4, 0), operand(5, 0));
        drain();

        for (int k = 0; k < N_RAND; k++) begin
            op  = fpu_op_e'($urandom_range(5, 0));
            fmt = 2'($urandom_range(3, 0));
            send(op, fmt, 3'($urandom_range(op == FCMP ? 2 : 3, 0)),
                 operand($urandom_range(10, 0), fmt == 2'b01),
                 operand($urandom_range(10, 0), fmt == 2'b01));
        end
        drain();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- hw/fpu_wrap.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_wrap import fpu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     fpu_valid_i,
    output logic                     fpu_ready_o,
    input  fpu_op_e                  fpu_op_i,
    input  logic [1:0]               fpu_fmt_i,
    input  logic [2:0]               fpu_rm_i,
    input  logic [`FPU_FLEN-1:0]     operand_a_i,
    input  logic [`FPU_FLEN-1:0]     operand_b_i,
    input  logic [`FPU_TAG_W-1:0]    trans_id_i,
    output logic [`FPU_FLEN-1:0]     result_o,
    output logic [`FPU_TAG_W-1:0]    fpu_trans_id_o,
    output logic [`FPU_STATUS_W-1:0] fpu_status_o,
    output logic                     fpu_valid_o
);

    fpu_req_if dec_req ();
    fpu_req_if unit_req ();

    fpu_op_decode i_op_decode (
        .fpu_op_i,
        .fpu_fmt_i,
        .fpu_rm_i,
        .operand_a_i,
        .operand_b_i,
        .trans_id_i,
        .req_o       (dec_req)
    );

    fpu_issue_ctrl i_issue_ctrl (
        .clk_i,
        .rst_ni,
        .flush_i,
        .fpu_valid_i,
        .fpu_ready_o,
        .dec_i       (dec_req),
        .req_o       (unit_req)
    );

    fpu_noncomp_unit i_noncomp_unit (
        .clk_i,
        .rst_ni,
        .flush_i,
        .req_i    (unit_req),
        .result_o,
        .tag_o    (fpu_trans_id_o),
        .status_o (fpu_status_o),
        .valid_o  (fpu_valid_o)
    );

endmodule

//--- hw/fpu_noncomp_unit.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_noncomp_unit import fpu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    fpu_req_if.unit                  req_i,
    output logic [`FPU_FLEN-1:0]     result_o,
    output logic [`FPU_TAG_W-1:0]    tag_o,
    output logic [`FPU_STATUS_W-1:0] status_o,
    output logic                     valid_o
);

    logic [1:0][`FPU_FLEN-1:0] opnd;
    logic [1:0][`FPU_FLEN-2:0] mag;
    logic [1:0]                sgn, exp_max, exp_min, man_zero, quiet;
    logic [1:0]                is_nan, is_snan;
    logic                      fmt32, mag_lt, mag_eq, ord_lt;

    assign opnd  = {req_i.operand_b, req_i.operand_a}; // index 0 is operand a.
    assign fmt32 = (req_i.fmt == FMT_FP32);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (fmt32) begin
                sgn[i]      = opnd[i][31];
                exp_max[i]  = &opnd[i][30:23];
                exp_min[i]  = ~|opnd[i][30:23];
                man_zero[i] = ~|opnd[i][22:0];
                quiet[i]    = opnd[i][22];
                mag[i]      = {32'b0, opnd[i][30:0]};
            end else begin
                sgn[i]      = opnd[i][63];
                exp_max[i]  = &opnd[i][62:52];
                exp_min[i]  = ~|opnd[i][62:52];
                man_zero[i] = ~|opnd[i][51:0];
                quiet[i]    = opnd[i][51];
                mag[i]      = opnd[i][62:0];
            end
        end
    end

    assign is_nan  = exp_max & ~man_zero;
    assign is_snan = is_nan & ~quiet;
    assign mag_lt  = (mag[0] < mag[1]);
    assign mag_eq  = (mag[0] == mag[1]);
    // total order on the raw bits, so -0 sorts below +0.
    assign ord_lt  = (sgn[0] != sgn[1]) ? sgn[0] : (sgn[0] ? !mag_lt && !mag_eq : mag_lt);

    logic                 is_short, ready, short_acc, long_acc;
    logic                 sgn_new, short_nv;
    logic [`FPU_FLEN-1:0] short_res, short_box;

    always_comb begin
        case (req_i.mode)
            2'd0:    sgn_new = sgn[1];
            2'd1:    sgn_new = ~sgn[1];
            2'd2:    sgn_new = sgn[0] ^ sgn[1];
            default: sgn_new = sgn[0]; // pass-through for moves.
        endcase
        short_nv = 1'b0;
        if (req_i.op == NC_MINMAX) begin
            short_nv = |is_snan;
            if (&is_nan) begin
                short_res = fmt32 ? {32'b0, `FPU_QNAN32} : `FPU_QNAN64;
            end else if (is_nan[0]) begin
                short_res = opnd[1];
            end else if (is_nan[1]) begin
                short_res = opnd[0];
            end else begin
                short_res = (ord_lt ^ req_i.mode[0]) ? opnd[0] : opnd[1];
            end
        end else if (fmt32) begin
            short_res = {opnd[0][63:32], sgn_new, opnd[0][30:0]};
        end else begin
            short_res = {sgn_new, opnd[0][62:0]};
        end
        short_box = short_res;
        if (fmt32) begin
            // nan-box single results, sign-extend moves into the integer file.
            short_box[63:32] = req_i.int_dst ? {32{short_res[31]}} : 32'hffff_ffff;
        end
    end

    logic                  l1_valid, l1_class, l1_sgn_a, l1_exp_max_a;
    logic [1:0]            l1_mode, l1_exp_min, l1_man_zero, l1_nan, l1_snan;
    logic                  l1_ord_lt, l1_raw_eq;
    logic [`FPU_TAG_W-1:0] l1_tag;

    // a short op cannot share the output register with a long op leaving stage 1.
    assign is_short    = (req_i.op == NC_SGNJ) || (req_i.op == NC_MINMAX);
    assign ready       = !(l1_valid && req_i.valid && is_short);
    assign req_i.ready = ready;
    assign short_acc   = req_i.valid && ready && is_short;
    assign long_acc    = req_i.valid && ready && !is_short;

    always_ff @(posedge clk_i) begin
        if (long_acc) begin
            l1_class     <= (req_i.op == NC_CLASS);
            l1_mode      <= req_i.mode;
            l1_tag       <= req_i.tag;
            l1_sgn_a     <= sgn[0];
            l1_exp_max_a <= exp_max[0];
            l1_exp_min   <= exp_min;
            l1_man_zero  <= man_zero;
            l1_nan       <= is_nan;
            l1_snan      <= is_snan;
            l1_ord_lt    <= ord_lt;
            l1_raw_eq    <= mag_eq && (sgn[0] == sgn[1]);
        end
    end

    logic                    both_zero, cmp_lt, cmp_eq, long_nv;
    logic [`FPU_CLASS_W-1:0] class_mask;
    logic [`FPU_FLEN-1:0]    long_res;

    always_comb begin
        both_zero  = &(l1_exp_min & l1_man_zero);
        cmp_lt     = l1_ord_lt && !both_zero && !(|l1_nan);
        cmp_eq     = (l1_raw_eq || both_zero) && !(|l1_nan);
        class_mask = '0;
        if (l1_nan[0]) begin
            class_mask[l1_snan[0] ? 8 : 9] = 1'b1;
        end else if (l1_exp_max_a) begin
            class_mask[l1_sgn_a ? 0 : 7] = 1'b1;
        end else if (!l1_exp_min[0]) begin
            class_mask[l1_sgn_a ? 1 : 6] = 1'b1;
        end else if (!l1_man_zero[0]) begin
            class_mask[l1_sgn_a ? 2 : 5] = 1'b1;
        end else begin
            class_mask[l1_sgn_a ? 3 : 4] = 1'b1;
        end
        long_res = '0;
        long_nv  = 1'b0;
        if (l1_class) begin
            long_res[`FPU_CLASS_W-1:0] = class_mask;
        end else begin
            case (l1_mode)
                2'd0: begin
                    long_res[0] = cmp_lt || cmp_eq;
                    long_nv     = |l1_nan; // signaling compare.
                end
                2'd1: begin
                    long_res[0] = cmp_lt;
                    long_nv     = |l1_nan;
                end
                2'd2: begin
                    long_res[0] = cmp_eq;
                    long_nv     = |l1_snan;
                end
                default: long_nv = |l1_snan;
            endcase
        end
    end

    logic out_valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            l1_valid    <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            l1_valid    <= long_acc && !flush_i;
            out_valid_q <= (l1_valid || short_acc) && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (l1_valid) begin
            result_o <= long_res;
            tag_o    <= l1_tag;
            status_o <= {long_nv, {(`FPU_STATUS_W-1){1'b0}}};
        end else if (short_acc) begin
            result_o <= short_box;
            tag_o    <= req_i.tag;
            status_o <= {short_nv, {(`FPU_STATUS_W-1){1'b0}}};
        end
    end

    // a flush also drops the result leaving in that cycle.
    assign valid_o = out_valid_q && !flush_i;

endmodule

//--- hw/fpu_issue_ctrl.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_issue_ctrl import fpu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     fpu_valid_i,
    output logic     fpu_ready_o,
    fpu_req_if.issue dec_i,
    fpu_req_if.issue req_o
);

    issue_state_e state_q, state_d;
    logic         hold;
    logic         use_hold;
    logic         unit_valid;

    logic [`FPU_FLEN-1:0]  operand_a_q;
    logic [`FPU_FLEN-1:0]  operand_b_q;
    nc_op_e                op_q;
    logic [1:0]            mode_q;
    fp_fmt_e               fmt_q;
    logic                  int_dst_q;
    logic [`FPU_TAG_W-1:0] tag_q;

    always_comb begin
        state_d     = state_q;
        fpu_ready_o = 1'b0;
        unit_valid  = 1'b0;
        hold        = 1'b0;
        use_hold    = 1'b0;
        unique case (state_q)
            ST_READY: begin
                fpu_ready_o = 1'b1;
                unit_valid  = fpu_valid_i;
                if (fpu_valid_i && !req_o.ready) begin
                    fpu_ready_o = 1'b0; // refused, keep a copy.
                    hold        = 1'b1;
                    state_d     = ST_STALL;
                end
            end
            ST_STALL: begin
                unit_valid = 1'b1;
                use_hold   = 1'b1;
                if (req_o.ready) begin
                    fpu_ready_o = 1'b1;
                    state_d     = ST_READY;
                end
            end
            default: ;
        endcase
        if (flush_i) begin
            state_d = ST_READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold) begin
            operand_a_q <= dec_i.operand_a;
            operand_b_q <= dec_i.operand_b;
            op_q        <= dec_i.op;
            mode_q      <= dec_i.mode;
            fmt_q       <= dec_i.fmt;
            int_dst_q   <= dec_i.int_dst;
            tag_q       <= dec_i.tag;
        end
    end

    assign req_o.valid     = unit_valid;
    assign req_o.operand_a = use_hold ? operand_a_q : dec_i.operand_a;
    assign req_o.operand_b = use_hold ? operand_b_q : dec_i.operand_b;
    assign req_o.op        = use_hold ? op_q : dec_i.op;
    assign req_o.mode      = use_hold ? mode_q : dec_i.mode;
    assign req_o.fmt       = use_hold ? fmt_q : dec_i.fmt;
    assign req_o.int_dst   = use_hold ? int_dst_q : dec_i.int_dst;
    assign req_o.tag       = use_hold ? tag_q : dec_i.tag;

endmodule

//--- hw/fpu_op_decode.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_op_decode import fpu_pkg::*; (
    input  fpu_op_e               fpu_op_i,
    input  logic [1:0]            fpu_fmt_i,
    input  logic [2:0]            fpu_rm_i,
    input  logic [`FPU_FLEN-1:0]  operand_a_i,
    input  logic [`FPU_FLEN-1:0]  operand_b_i,
    input  logic [`FPU_TAG_W-1:0] trans_id_i,
    fpu_req_if.dec                req_o
);

    nc_op_e     op;
    logic [1:0] mode;
    logic       int_dst;

    always_comb begin
        op      = NC_SGNJ;
        mode    = fpu_rm_i[1:0];
        int_dst = 1'b0;
        unique case (fpu_op_i)
            FSGNJ: begin
                op = NC_SGNJ;
            end
            FMIN_MAX: begin
                op = NC_MINMAX;
            end
            FCMP: begin
                op      = NC_CMP;
                int_dst = 1'b1;
            end
            FCLASS: begin
                op      = NC_CLASS;
                int_dst = 1'b1;
            end
            // raw moves keep operand a untouched.
            FMV_F2X: begin
                op      = NC_SGNJ;
                mode    = 2'd3;
                int_dst = 1'b1;
            end
            FMV_X2F: begin
                op   = NC_SGNJ;
                mode = 2'd3;
            end
            default: ;
        endcase
    end

    assign req_o.op      = op;
    assign req_o.mode    = mode;
    assign req_o.int_dst = int_dst;

    // only code 01 selects double, anything with bit 1 set runs as single.
    assign req_o.fmt = (fpu_fmt_i == 2'b01) ? FMT_FP64 : FMT_FP32;

    assign req_o.operand_a = operand_a_i;
    assign req_o.operand_b = operand_b_i;
    assign req_o.tag       = trans_id_i;

endmodule

//--- hw/fpu_req_if.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

interface fpu_req_if import fpu_pkg::*; ();

    wire [`FPU_FLEN-1:0]  operand_a;
    wire [`FPU_FLEN-1:0]  operand_b;
    wire nc_op_e          op;
    wire [1:0]            mode;    // sign mode, min/max select or compare kind.
    wire fp_fmt_e         fmt;
    wire                  int_dst; // result goes to the integer file.
    wire [`FPU_TAG_W-1:0] tag;
    wire                  valid;
    wire                  ready;

    modport dec (output operand_a, operand_b, op, mode, fmt, int_dst, tag);

    // issue control reads the decoded request and drives the unit request.
    modport issue (inout operand_a, operand_b, op, mode, fmt, int_dst, tag, valid, ready);

    modport unit (
        input  operand_a, operand_b, op, mode, fmt, int_dst, tag, valid,
        output ready
    );

endinterface

//--- hw/fpu_pkg.sv
package fpu_pkg;

    // opcodes as issued by the core.
    typedef enum logic [2:0] {
        FSGNJ,
        FMIN_MAX,
        FCMP,
        FCLASS,
        FMV_F2X,
        FMV_X2F
    } fpu_op_e;

    // operations of the non-computational unit.
    typedef enum logic [1:0] {
        NC_SGNJ,
        NC_MINMAX,
        NC_CMP,
        NC_CLASS
    } nc_op_e;

    typedef enum logic {
        FMT_FP32,
        FMT_FP64
    } fp_fmt_e;

    typedef enum logic {
        ST_READY,
        ST_STALL
    } issue_state_e;

endpackage

//--- hw/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// datapath and tag widths.
`define FPU_FLEN     64
`define FPU_TAG_W    3
`define FPU_STATUS_W 5
`define FPU_CLASS_W  10

// canonical quiet nans.
`define FPU_QNAN32 32'h7fc0_0000
`define FPU_QNAN64 64'h7ff8_0000_0000_0000

`endif
